//--- Makefile
TOP = tb_accum_warp_looper

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f accum_warp_looper.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) \
		-f accum_warp_looper.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- accum_offset_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "accum_warp_looper_cfg.svh"

module accum_offset_counter
	import accum_warp_looper_pkg::*;
(
	input  wire                        i_clk,
	input  wire                        i_rst_n,
	input  logic                       i_start,
	input  logic [`VDIM-1:0][`WBW-1:0] i_a_beg,
	input  logic [`VDIM-1:0][`WBW-1:0] i_a_end,
	output logic                       o_done,
	// Offset channel
	output logic                       o_aofs_rdy,
	output aofs_t                      o_aofs,
	input  logic                       i_aofs_ack
);

	logic [`VDIM-1:0][`WBW-1:0] ofs;
	logic [`VDIM-1:0][`WBW-1:0] ofs_nxt;
	logic [`VDIM-1:0]           at_end;
	logic                       carry;
	logic                       xfer;

	// Last point of each dimension, one bit wider so end at the top value works
	always_comb begin
		for (int d = 0; d < `VDIM; d++) begin
			at_end[d] = ({1'b0, ofs[d]} + 1'b1) >= {1'b0, i_a_end[d]};
		end
	end

	// Odometer step, dimension 0 innermost
	always_comb begin
		carry = 1'b1;
		ofs_nxt = ofs;
		for (int d = 0; d < `VDIM; d++) begin
			if (carry) begin
				if (at_end[d]) begin
					ofs_nxt[d] = i_a_beg[d];
				end else begin
					ofs_nxt[d] = ofs[d] + 1'b1;
					carry = 1'b0;
				end
			end
		end
	end

	assign xfer = o_aofs_rdy && i_aofs_ack;
	assign o_aofs = '{ofs: ofs, islast: &at_end};
	assign o_done = xfer && o_aofs.islast;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_aofs_rdy <= 1'b0;
			ofs <= '0;
		end else if (i_start) begin
			o_aofs_rdy <= 1'b1;
			ofs <= i_a_beg;
		end else if (xfer) begin
			if (o_aofs.islast)
				o_aofs_rdy <= 1'b0;
			else
				ofs <= ofs_nxt;
		end
	end

	// Offered offsets never leave the commanded range
	for (genvar d = 0; d < `VDIM; d++) begin : g_range_chk
		a_ofs_in_range: assert property (
			@(posedge i_clk) disable iff (!i_rst_n)
			o_aofs_rdy |-> (ofs[d] >= i_a_beg[d]) && (ofs[d] < i_a_end[d])
		);
	end

endmodule

`default_nettype wire

//--- accum_warp_looper.f
+incdir+.
accum_warp_looper_pkg.sv
looper_ctrl.sv
accum_offset_counter.sv
mem_ofs_stage.sv
vector_addr_stage.sv
accum_warp_looper.sv
tb_accum_warp_looper.sv

//--- accum_warp_looper.sv
`timescale 1ns/1ps
`default_nettype none

module accum_warp_looper
	import accum_warp_looper_pkg::*;
(
	input  wire         i_clk,
	input  wire         i_rst_n,
	// Command channel
	input  logic        i_cmd_rdy,
	input  looper_cmd_t i_cmd,
	output logic        o_cmd_ack,
	// Address vector channel
	output logic        o_av_rdy,
	output addr_vec_t   o_av,
	input  logic        i_av_ack
);

	logic  cmd_empty;
	logic  cnt_start;
	logic  cnt_done;
	logic  retire_xfer;
	logic  aofs_rdy;
	logic  aofs_ack;
	aofs_t aofs;
	logic  mofs_rdy;
	logic  mofs_ack;
	mofs_t mofs;

	assign cmd_empty = range_empty(i_cmd);
	assign retire_xfer = o_av_rdy && i_av_ack && o_av.retire;

	// ==============================
	// Control and pipeline
	// ==============================
	looper_ctrl u_ctrl (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_cmd_rdy     (i_cmd_rdy),
		.i_cmd_empty   (cmd_empty),
		.o_cmd_ack     (o_cmd_ack),
		.o_cnt_start   (cnt_start),
		.i_cnt_done    (cnt_done),
		.i_retire_xfer (retire_xfer)
	);

	accum_offset_counter u_cnt (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_start    (cnt_start),
		.i_a_beg    (i_cmd.a_beg),
		.i_a_end    (i_cmd.a_end),
		.o_done     (cnt_done),
		.o_aofs_rdy (aofs_rdy),
		.o_aofs     (aofs),
		.i_aofs_ack (aofs_ack)
	);

	mem_ofs_stage u_mofs (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_aofs_rdy (aofs_rdy),
		.o_aofs_ack (aofs_ack),
		.i_aofs     (aofs),
		.i_base     (i_cmd.base),
		.i_a_stride (i_cmd.a_stride),
		.o_mofs_rdy (mofs_rdy),
		.i_mofs_ack (mofs_ack),
		.o_mofs     (mofs)
	);

	vector_addr_stage u_vec (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_mofs_rdy  (mofs_rdy),
		.o_mofs_ack  (mofs_ack),
		.i_mofs      (mofs),
		.i_b_ofs     (i_cmd.b_ofs),
		.i_b_bound   (i_cmd.b_bound),
		.i_lane_step (i_cmd.lane_step),
		.o_av_rdy    (o_av_rdy),
		.i_av_ack    (i_av_ack),
		.o_av        (o_av)
	);

endmodule

`default_nettype wire

//--- accum_warp_looper_cfg.svh
`ifndef ACCUM_WARP_LOOPER_CFG_SVH
`define ACCUM_WARP_LOOPER_CFG_SVH

// ==============================
// Datapath sizes
// ==============================

// Width of one accumulation offset, boundary or stride
`define WBW 16

// Global address width, all address math wraps at this width
`define ABW 32

// ==============================
// Warp shape
// ==============================

// Number of accumulation dimensions, dimension 0 runs innermost
`define VDIM 2

// Lanes per warp, one address per lane in every vector
`define VSIZE 4

`endif

//--- accum_warp_looper_pkg.sv
`default_nettype none

`include "accum_warp_looper_cfg.svh"

package accum_warp_looper_pkg;

	// ==============================
	// Controller state
	// ==============================
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		RUN   = 2'd1,
		DRAIN = 2'd2
	} looper_state_e;

	// ==============================
	// Command and stage payloads
	// ==============================

	// One command, held on the input channel until acknowledged
	typedef struct packed {
		logic [`WBW-1:0]            b_ofs;
		logic [`WBW-1:0]            b_bound;
		logic [`VDIM-1:0][`WBW-1:0] a_beg;
		// Exclusive end per dimension
		logic [`VDIM-1:0][`WBW-1:0] a_end;
		logic [`VDIM-1:0][`WBW-1:0] a_stride;
		logic [`ABW-1:0]            base;
		logic [`WBW-1:0]            lane_step;
	} looper_cmd_t;

	// Counter to memory offset stage
	typedef struct packed {
		logic [`VDIM-1:0][`WBW-1:0] ofs;
		logic                       islast;
	} aofs_t;

	// Memory offset stage to vector stage
	typedef struct packed {
		logic [`ABW-1:0] addr;
		logic            islast;
	} mofs_t;

	// One output vector of lane addresses
	typedef struct packed {
		logic [`VSIZE-1:0][`ABW-1:0] addr;
		logic [`VSIZE-1:0]           valid;
		logic                        retire;
	} addr_vec_t;

	// Range is empty when any dimension has end at or below begin
	function automatic logic range_empty(input looper_cmd_t cmd);
		logic empty;
		empty = 1'b0;
		for (int d = 0; d < `VDIM; d++) begin
			if (cmd.a_end[d] <= cmd.a_beg[d])
				empty = 1'b1;
		end
		return empty;
	endfunction

endpackage

`default_nettype wire

//--- looper_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module looper_ctrl
	import accum_warp_looper_pkg::*;
(
	input  wire  i_clk,
	input  wire  i_rst_n,
	// Command channel
	input  logic i_cmd_rdy,
	input  logic i_cmd_empty,
	output logic o_cmd_ack,
	// Offset counter
	output logic o_cnt_start,
	input  logic i_cnt_done,
	// Retire vector accepted downstream
	input  logic i_retire_xfer
);

	looper_state_e state;
	looper_state_e state_nxt;

	// ==============================
	// Outputs
	// ==============================

	// One start per command, only when there is something to walk
	assign o_cnt_start = (state == IDLE) && i_cmd_rdy && !i_cmd_empty;

	// Empty range acks right away, otherwise wait for the retire vector
	assign o_cmd_ack = (state == DRAIN) && (i_cmd_empty || i_retire_xfer);

	// ==============================
	// Next state
	// ==============================
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (i_cmd_rdy)
					state_nxt = i_cmd_empty ? DRAIN : RUN;
			end
			RUN: begin
				// Last offset handed to the pipeline
				if (i_cnt_done)
					state_nxt = DRAIN;
			end
			DRAIN: begin
				if (o_cmd_ack)
					state_nxt = IDLE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Ack only ever answers a pending command
	a_ack_needs_rdy: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		o_cmd_ack |-> i_cmd_rdy
	);

endmodule

`default_nettype wire

//--- mem_ofs_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "accum_warp_looper_cfg.svh"

module mem_ofs_stage
	import accum_warp_looper_pkg::*;
(
	input  wire                        i_clk,
	input  wire                        i_rst_n,
	// Offsets from the counter
	input  logic                       i_aofs_rdy,
	output logic                       o_aofs_ack,
	input  aofs_t                      i_aofs,
	// Command fields
	input  logic [`ABW-1:0]            i_base,
	input  logic [`VDIM-1:0][`WBW-1:0] i_a_stride,
	// Linear address to the vector stage
	output logic                       o_mofs_rdy,
	input  logic                       i_mofs_ack,
	output mofs_t                      o_mofs
);

	logic [`ABW-1:0] lin;
	logic [`ABW-1:0] ofs_ext;
	logic [`ABW-1:0] stride_ext;
	logic            load;

	// ==============================
	// Linear address
	// ==============================

	// base + sum(ofs * stride), wraps at ABW bits
	always_comb begin
		lin = i_base;
		ofs_ext = '0;
		stride_ext = '0;
		for (int d = 0; d < `VDIM; d++) begin
			ofs_ext = {{(`ABW - `WBW){1'b0}}, i_aofs.ofs[d]};
			stride_ext = {{(`ABW - `WBW){1'b0}}, i_a_stride[d]};
			lin = lin + ofs_ext * stride_ext;
		end
	end

	// ==============================
	// Holding register
	// ==============================

	// Take a new item when empty or when the held one leaves this cycle
	assign o_aofs_ack = !o_mofs_rdy || i_mofs_ack;
	assign load = i_aofs_rdy && o_aofs_ack;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_mofs_rdy <= 1'b0;
		end else if (load) begin
			o_mofs_rdy <= 1'b1;
		end else if (i_mofs_ack) begin
			o_mofs_rdy <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (load)
			o_mofs <= '{addr: lin, islast: i_aofs.islast};
	end

	// Stalled output keeps its item untouched
	a_mofs_hold: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		o_mofs_rdy && !i_mofs_ack |=> o_mofs_rdy && $stable(o_mofs)
	);

endmodule

`default_nettype wire

//--- tb_accum_warp_looper.sv
`timescale 1ns/1ps
`default_nettype none

`include "accum_warp_looper_cfg.svh"

module tb_accum_warp_looper
	import accum_warp_looper_pkg::*;
();

	localparam int NCMD = 8;

	logic        i_clk;
	logic        i_rst_n;
	logic        i_cmd_rdy;
	looper_cmd_t i_cmd;
	logic        o_cmd_ack;
	logic        o_av_rdy;
	addr_vec_t   o_av;
	logic        i_av_ack;

	// Stimulus table with one command and one ack probability in percent per row
	looper_cmd_t cmd_tab [NCMD];
	int          ack_pct [NCMD];

	// Vectors the model expects for the current command
	addr_vec_t   exp_q [$];

	accum_warp_looper i_accum_warp_looper (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_cmd_rdy (i_cmd_rdy),
		.i_cmd     (i_cmd),
		.o_cmd_ack (o_cmd_ack),
		.o_av_rdy  (o_av_rdy),
		.o_av      (o_av),
		.i_av_ack  (i_av_ack)
	);

	initial begin
		i_clk = 1'b0;
		forever #10 i_clk = ~i_clk;
	end

	// ==============================
	// Table and model
	// ==============================
	function automatic looper_cmd_t make_cmd(
		input logic [`WBW-1:0] b_ofs,
		input logic [`WBW-1:0] b_bound,
		input logic [`WBW-1:0] beg0,
		input logic [`WBW-1:0] beg1,
		input logic [`WBW-1:0] end0,
		input logic [`WBW-1:0] end1,
		input logic [`WBW-1:0] s0,
		input logic [`WBW-1:0] s1,
		input logic [`ABW-1:0] base,
		input logic [`WBW-1:0] lane_step
	);
		looper_cmd_t c;
		c = '0;
		c.b_ofs = b_ofs;
		c.b_bound = b_bound;
		c.a_beg[0] = beg0;
		c.a_beg[1] = beg1;
		c.a_end[0] = end0;
		c.a_end[1] = end1;
		c.a_stride[0] = s0;
		c.a_stride[1] = s1;
		c.base = base;
		c.lane_step = lane_step;
		return c;
	endfunction

	task automatic load_table();
		// Plain 2x3 walk with all lanes valid
		cmd_tab[0] = make_cmd(16'd0, 16'd4, 16'd0, 16'd0, 16'd2, 16'd3,
			16'd4, 16'd64, 32'h0000_1000, 16'd1);
		ack_pct[0] = 100;
		// Same walk under back-pressure
		cmd_tab[1] = cmd_tab[0];
		ack_pct[1] = 40;
		// Lane boundary keeps lanes 0 and 1
		cmd_tab[2] = make_cmd(16'd2, 16'd4, 16'd1, 16'd1, 16'd2, 16'd3,
			16'd8, 16'd32, 32'h0000_4000, 16'd16);
		ack_pct[2] = 100;
		// Empty in dimension 0
		cmd_tab[3] = make_cmd(16'd0, 16'd4, 16'd5, 16'd0, 16'd5, 16'd2,
			16'd1, 16'd1, 32'h0000_0100, 16'd1);
		ack_pct[3] = 100;
		cmd_tab[4] = make_cmd(16'd0, 16'd3, 16'd0, 16'd0, 16'd3, 16'd2,
			16'd8, 16'd256, 32'h0000_2000, 16'd2);
		ack_pct[4] = 70;
		// Base near the top so addresses wrap around
		cmd_tab[5] = make_cmd(16'd0, 16'd4, 16'd0, 16'd0, 16'd2, 16'd2,
			16'h0010, 16'h1000, 32'hffff_fff0, 16'h0004);
		ack_pct[5] = 100;
		// End below begin in dimension 1
		cmd_tab[6] = make_cmd(16'd0, 16'd4, 16'd0, 16'd4, 16'd3, 16'd2,
			16'd1, 16'd1, 32'h0000_0200, 16'd1);
		ack_pct[6] = 60;
		// Offsets and lane positions at the top of the 16-bit range
		cmd_tab[7] = make_cmd(16'hfffe, 16'hffff, 16'hfffd, 16'd7, 16'hffff, 16'd8,
			16'd1, 16'd2, 32'h8000_0000, 16'd3);
		ack_pct[7] = 50;
	endtask

	// Walk the range with dimension 0 innermost
	task automatic build_expected(input looper_cmd_t cmd);
		addr_vec_t       v;
		logic [`ABW-1:0] lin;
		logic [`ABW-1:0] step;
		logic [`ABW-1:0] s0;
		logic [`ABW-1:0] s1;
		exp_q.delete();
		step = {{(`ABW - `WBW){1'b0}}, cmd.lane_step};
		s0 = {{(`ABW - `WBW){1'b0}}, cmd.a_stride[0]};
		s1 = {{(`ABW - `WBW){1'b0}}, cmd.a_stride[1]};
		for (int d1 = int'(cmd.a_beg[1]); d1 < int'(cmd.a_end[1]); d1++) begin
			for (int d0 = int'(cmd.a_beg[0]); d0 < int'(cmd.a_end[0]); d0++) begin
				lin = cmd.base + d0[`ABW-1:0] * s0 + d1[`ABW-1:0] * s1;
				for (int k = 0; k < `VSIZE; k++) begin
					v.addr[k] = lin + k[`ABW-1:0] * step;
					v.valid[k] = (int'(cmd.b_ofs) + k) < int'(cmd.b_bound);
				end
				v.retire = (d0 == int'(cmd.a_end[0]) - 1)
					&& (d1 == int'(cmd.a_end[1]) - 1);
				exp_q.push_back(v);
			end
		end
	endtask

	function automatic logic draw_ack(input int pct);
		return ($urandom % 100) < pct;
	endfunction

	// ==============================
	// Compare tasks
	// ==============================
	task automatic compare_av(input addr_vec_t got, input addr_vec_t exp,
		input int cmd_idx, input int vec_idx);
		if (got !== exp) begin
			$display("[ERROR] %0t: cmd %0d vec %0d got %h %b %b expected %h %b %b",
				$time, cmd_idx, vec_idx, got.addr, got.valid, got.retire,
				exp.addr, exp.valid, exp.retire);
			$display("SOME TESTS FAILED");
			$fatal(1, "Address vector mismatch");
		end
	endtask

	task automatic compare_count(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "Count mismatch");
		end
	endtask

	// ==============================
	// Command runner
	// ==============================
	task automatic run_command(input int idx);
		looper_cmd_t cmd;
		int          pct;
		int          n_exp;
		int          n_got;
		int          cyc;
		int          limit;
		int          first_rdy;
		logic        acked;
		logic        xfer;
		cmd = cmd_tab[idx];
		pct = ack_pct[idx];
		build_expected(cmd);
		n_exp = exp_q.size();
		n_got = 0;
		cyc = 0;
		first_rdy = -1;
		acked = 1'b0;
		limit = 20 + 40 * n_exp;

		@(posedge i_clk);
		#1;
		i_cmd = cmd;
		i_cmd_rdy = 1'b1;
		i_av_ack = draw_ack(pct);

		while (!acked) begin
			// Sample mid-cycle where all outputs have settled
			@(negedge i_clk);
			xfer = o_av_rdy && i_av_ack;
			if (o_av_rdy && first_rdy < 0)
				first_rdy = cyc;
			if (xfer) begin
				if (n_got >= n_exp)
					compare_count(n_got + 1, n_exp, "vectors received");
				else
					compare_av(o_av, exp_q[n_got], idx, n_got);
				n_got++;
			end
			if (o_cmd_ack) begin
				acked = 1'b1;
				// Ack must coincide with the retire transfer
				compare_count(int'(xfer && o_av.retire), int'(n_exp > 0),
					"retire transfer in ack cycle");
			end else if (cyc >= limit) begin
				$display("Timeout: command %0d was not acknowledged within %0d cycles",
					idx, limit);
				$display("SOME TESTS FAILED");
				$fatal(1, "Simulation stopped on timeout");
			end else begin
				cyc++;
				@(posedge i_clk);
				#1;
				i_av_ack = draw_ack(pct);
			end
		end

		compare_count(n_got, n_exp, "vectors per command");
		if (n_exp > 0)
			compare_count(first_rdy, 3, "cycles to first vector");
		else
			compare_count(cyc, 1, "cycles to ack of empty range");

		// Without back-pressure one vector leaves per cycle
		if (n_exp > 0 && pct == 100)
			compare_count(cyc, 3 + n_exp - 1, "cycles to ack without back-pressure");

		@(posedge i_clk);
		#1;
		i_cmd_rdy = 1'b0;
		i_av_ack = 1'b0;

		// Ack is a single pulse per command
		@(negedge i_clk);
		compare_count(int'(o_cmd_ack), 0, "o_cmd_ack after acknowledge");
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		int seed_ret;
		seed_ret = $urandom(32'hc4e0_040e);
		i_rst_n = 1'b0;
		i_cmd_rdy = 1'b0;
		i_cmd = '0;
		i_av_ack = 1'b0;
		load_table();

		repeat (4) @(posedge i_clk);
		#1;
		compare_count(int'(o_cmd_ack), 0, "o_cmd_ack in reset");
		compare_count(int'(o_av_rdy), 0, "o_av_rdy in reset");
		i_rst_n = 1'b1;

		for (int i = 0; i < NCMD; i++) begin
			run_command(i);
		end

		repeat (2) @(posedge i_clk);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vector_addr_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "accum_warp_looper_cfg.svh"

module vector_addr_stage
	import accum_warp_looper_pkg::*;
(
	input  wire             i_clk,
	input  wire             i_rst_n,
	// Linear address from the memory offset stage
	input  logic            i_mofs_rdy,
	output logic            o_mofs_ack,
	input  mofs_t           i_mofs,
	// Command fields for the lane expansion
	input  logic [`WBW-1:0] i_b_ofs,
	input  logic [`WBW-1:0] i_b_bound,
	input  logic [`WBW-1:0] i_lane_step,
	// Address vector out
	output logic            o_av_rdy,
	input  logic            i_av_ack,
	output addr_vec_t       o_av
);

	logic [`VSIZE-1:0][`ABW-1:0] lane_addr;
	logic [`VSIZE-1:0]           lane_valid;
	logic [`ABW-1:0]             addr_acc;
	logic [`ABW-1:0]             step_ext;
	logic [`WBW:0]               lane_pos;
	logic                        load;

	// ==============================
	// Lane expansion
	// ==============================

	// Lane k sits at addr + k*lane_step, valid while b_ofs + k < b_bound
	always_comb begin
		step_ext = {{(`ABW - `WBW){1'b0}}, i_lane_step};
		addr_acc = i_mofs.addr;
		lane_pos = {1'b0, i_b_ofs};
		for (int k = 0; k < `VSIZE; k++) begin
			lane_addr[k] = addr_acc;
			lane_valid[k] = lane_pos < {1'b0, i_b_bound};
			addr_acc = addr_acc + step_ext;
			// Extra bit keeps the compare honest near the top of the range
			lane_pos = lane_pos + 1'b1;
		end
	end

	// ==============================
	// Holding register
	// ==============================
	assign o_mofs_ack = !o_av_rdy || i_av_ack;
	assign load = i_mofs_rdy && o_mofs_ack;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_av_rdy <= 1'b0;
		end else if (load) begin
			o_av_rdy <= 1'b1;
		end else if (i_av_ack) begin
			o_av_rdy <= 1'b0;
		end
	end

	// Retire marks the final vector of the command
	always_ff @(posedge i_clk) begin
		if (load) begin
			o_av.addr <= lane_addr;
			o_av.valid <= lane_valid;
			o_av.retire <= i_mofs.islast;
		end
	end

	// Output stays offered until the consumer takes it
	a_av_rdy_hold: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		o_av_rdy && !i_av_ack |=> o_av_rdy
	);

endmodule

`default_nettype wire
